//--- sim.f
+incdir+.
dbg_pkg.sv
stage_select.sv
div10_step.sv
digit_sequencer.sv
panel_output.sv
debug_panel_top.sv
tb_debug_panel.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_debug_panel
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = test failed
PASS_MSG  = test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_debug_panel.sv
`include "dbg_defines.svh"

module tb_debug_panel
  import dbg_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam hex_bank_t all_blank = {`DBG_NUM_DIGITS{seg_blank}};
  localparam int reset_cycles = 4;
  localparam int settle_cycles = 8;
  // length of each test in cycles, each one opens with a drive edge
  localparam int test_cycles = reset_cycles
                               + (1 + 10)
                               + 7 * (1 + settle_cycles)
                               + 4 * (1 + settle_cycles)
                               + (1 + 1 + 7)
                               + (1 + 10 + settle_cycles)
                               + (1 + settle_cycles);
  localparam int watchdog_cycles = test_cycles + 150;

  logic                  clk;
  logic                  rst_n;
  probe_bank_t           probes;
  logic [`DBG_VAL_W-1:0] reg_value;
  logic [`DBG_SW_W-1:0]  sw;
  hex_bank_t             hex;
  logic [`DBG_SW_W-1:0]  ledr;

  debug_panel_top u_debug_panel_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .probes    (probes),
    .reg_value (reg_value),
    .sw        (sw),
    .hex       (hex),
    .ledr      (ledr)
  );

  always #5 clk = ~clk;

  task automatic abort_run();
    $display("test failed");
    $fatal(1);
  endtask

  // six decimal digits of the value with units in index 0
  function automatic hex_bank_t expected_digits(input logic [`DBG_VAL_W-1:0] value);
    hex_bank_t   exp;
    int unsigned rest;
    rest = 32'(value);
    for (int d = 0; d < `DBG_NUM_DIGITS; d++) begin
      exp[d] = seg_of_digit(4'(rest % 10));
      rest = rest / 10;
    end
    return exp;
  endfunction

  function automatic logic [`DBG_SW_W-1:0] expected_leds(input logic manual,
                                                        input logic show_reg,
                                                        input logic [`DBG_OP_W-1:0] op);
    if (!manual || show_reg) begin
      return '1;
    end
    return {{(`DBG_SW_W - `DBG_OP_W){1'b0}}, ~op};
  endfunction

  function automatic logic [`DBG_SW_W-1:0] switch_word(input logic manual,
                                                      input logic show_reg,
                                                      input logic [2:0] stage);
    logic [`DBG_SW_W-1:0] word;
    word = '0;
    word[`DBG_SW_MANUAL] = manual;
    word[`DBG_SW_SHOW_REG] = show_reg;
    word[2:0] = stage;
    return word;
  endfunction

  task automatic check_hex(input hex_bank_t expected);
    assert (hex === expected) else begin
      $display("CHECK FAILED time=%0t signal=hex expected=%h actual=%h", $time, expected, hex);
      abort_run();
    end
  endtask

  task automatic check_leds(input logic [`DBG_SW_W-1:0] expected);
    assert (ledr === expected) else begin
      $display("CHECK FAILED time=%0t signal=ledr expected=%h actual=%h", $time, expected, ledr);
      abort_run();
    end
  endtask

  task automatic randomize_probes();
    for (int i = 0; i < `DBG_NUM_STAGES; i++) begin
      probes[i].pc = 7'($urandom);
      probes[i].opcode = 7'($urandom);
    end
  endtask

  // auto mode blanks the digits and lights every LED
  task automatic blank_in_auto_mode();
    @(negedge clk);
    check_hex(all_blank);
    check_leds('1);
    sw = switch_word(1'b0, 1'b0, 3'd3);
    reg_value = 20'($urandom);
    repeat (10) @(negedge clk);
    check_hex(all_blank);
    check_leds('1);
  endtask

  task automatic show_each_stage();
    for (int s = 0; s < `DBG_NUM_STAGES; s++) begin
      @(negedge clk);
      randomize_probes();
      sw = switch_word(1'b1, 1'b0, 3'(s));
      repeat (settle_cycles) @(negedge clk);
      check_hex(expected_digits({{(`DBG_VAL_W - `DBG_PC_W){1'b0}}, probes[s].pc}));
      check_leds(expected_leds(1'b1, 1'b0, probes[s].opcode));
    end
  endtask

  // stage bits differ per call so each value gets a fresh sequence
  task automatic show_register_value(input logic [`DBG_VAL_W-1:0] value,
                                     input logic [2:0] stage);
    @(negedge clk);
    reg_value = value;
    sw = switch_word(1'b1, 1'b1, stage);
    repeat (settle_cycles) @(negedge clk);
    check_hex(expected_digits(value));
    check_leds('1);
  endtask

  task automatic restart_blanks_digits();
    logic [`DBG_VAL_W-1:0] next_value;
    next_value = 20'($urandom);
    @(negedge clk);
    reg_value = next_value;
    sw = switch_word(1'b1, 1'b1, 3'd4);
    // restart is sampled on the next rising edge
    @(negedge clk);
    check_hex(all_blank);
    repeat (7) @(negedge clk);
    check_hex(expected_digits(next_value));
  endtask

  task automatic value_held_until_restart();
    logic [`DBG_VAL_W-1:0] old_value;
    logic [`DBG_VAL_W-1:0] new_value;
    old_value = reg_value;
    new_value = old_value + 20'd1;
    @(negedge clk);
    reg_value = new_value;
    repeat (10) @(negedge clk);
    check_hex(expected_digits(old_value));
    sw = switch_word(1'b1, 1'b1, 3'd5);
    repeat (settle_cycles) @(negedge clk);
    check_hex(expected_digits(new_value));
  endtask

  // code 7 selects no stage so pc and opcode read as zero
  task automatic unused_stage_code();
    @(negedge clk);
    randomize_probes();
    sw = switch_word(1'b1, 1'b0, 3'd7);
    repeat (settle_cycles) @(negedge clk);
    check_hex(expected_digits('0));
    check_leds(expected_leds(1'b1, 1'b0, '0));
  endtask

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, the tests did not finish", watchdog_cycles);
    abort_run();
  end

  initial begin
    void'($urandom(32'h668f_7232));
    clk = 1'b0;
    rst_n = 1'b0;
    sw = '0;
    probes = '0;
    reg_value = '0;
    repeat (reset_cycles) @(negedge clk);
    rst_n = 1'b1;

    blank_in_auto_mode();
    show_each_stage();
    show_register_value(20'($urandom), 3'd0);
    show_register_value(20'($urandom), 3'd1);
    show_register_value(20'd999999, 3'd2);
    show_register_value(20'd1048575, 3'd3);
    restart_blanks_digits();
    value_held_until_restart();
    unused_stage_code();

    $display("test passed");
    $finish;
  end

endmodule

//--- debug_panel_top.sv
`include "dbg_defines.svh"

module debug_panel_top
  import dbg_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  probe_bank_t           probes,
  input  logic [`DBG_VAL_W-1:0] reg_value,
  input  logic [`DBG_SW_W-1:0]  sw,
  output hex_bank_t             hex,
  output logic [`DBG_SW_W-1:0]  ledr
);

  panel_ctrl_t           ctrl;
  logic [`DBG_VAL_W-1:0] target_value;
  logic [`DBG_OP_W-1:0]  opcode;
  hex_bank_t             digits;

  // switch decode and stage mux
  stage_select u_stage_select (
    .sw           (sw),
    .probes       (probes),
    .reg_value    (reg_value),
    .ctrl         (ctrl),
    .target_value (target_value),
    .opcode       (opcode)
  );

  // decimal conversion, one digit per clock
  digit_sequencer u_digit_sequencer (
    .clk          (clk),
    .rst_n        (rst_n),
    .sw           (sw),
    .target_value (target_value),
    .digits       (digits)
  );

  // blanking and LED drive
  panel_output u_panel_output (
    .ctrl   (ctrl),
    .digits (digits),
    .opcode (opcode),
    .hex    (hex),
    .ledr   (ledr)
  );

endmodule

//--- panel_output.sv
`include "dbg_defines.svh"

module panel_output
  import dbg_pkg::*;
(
  input  panel_ctrl_t          ctrl,
  input  hex_bank_t            digits,
  input  logic [`DBG_OP_W-1:0] opcode,
  output hex_bank_t            hex,
  output logic [`DBG_SW_W-1:0] ledr
);

  localparam hex_bank_t all_blank = {`DBG_NUM_DIGITS{seg_blank}};

  // digits only visible while stepping the clock by hand
  always_comb begin
    if (ctrl.manual_clk) begin
      hex = digits;
    end else begin
      hex = all_blank;
    end
  end

  // free running or register mode lights everything
  // otherwise the opcode is shown inverted
  always_comb begin
    if (!ctrl.manual_clk || ctrl.show_reg) begin
      ledr = '1;
    end else begin
      ledr = {{(`DBG_SW_W - `DBG_OP_W){1'b0}}, ~opcode};
    end
  end

endmodule

//--- digit_sequencer.sv
`include "dbg_defines.svh"

module digit_sequencer
  import dbg_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [`DBG_SW_W-1:0]  sw,
  input  logic [`DBG_VAL_W-1:0] target_value,
  output hex_bank_t             digits
);

  localparam int step_w = $clog2(`DBG_NUM_DIGITS + 1);
  localparam logic [step_w-1:0] last_step = step_w'(`DBG_NUM_DIGITS);
  localparam logic [`DBG_VAL_W-1:0] ten = `DBG_VAL_W'(10);
  localparam hex_bank_t all_blank = {`DBG_NUM_DIGITS{seg_blank}};

  logic [`DBG_SW_W-1:0]  sw_q;
  logic [step_w-1:0]     step;
  logic                  restart;
  logic [`DBG_VAL_W-1:0] div_in;
  logic [`DBG_VAL_W-1:0] quotient;
  logic [3:0]            remainder;
  logic [3:0]            units;

  // any switch movement starts the sequence over
  assign restart = (sw != sw_q);

  // step 0 captures the value, later steps keep dividing
  assign div_in = (step == '0) ? target_value : quotient;

  // units digit straight from the live value
  assign units = 4'(target_value % ten);

  div10_step u_div10_step (
    .clk       (clk),
    .rst_n     (rst_n),
    .div_in    (div_in),
    .quotient  (quotient),
    .remainder (remainder)
  );

  // one digit per clock, units first
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sw_q   <= '0;
      step   <= '0;
      digits <= all_blank;
    end else if (restart) begin
      sw_q   <= sw;
      step   <= '0;
      digits <= all_blank;
    end else if (step < last_step) begin
      if (step == '0) begin
        digits[0] <= seg_of_digit(units);
      end else begin
        digits[step] <= seg_of_digit(remainder);
      end
      step <= step + 1'b1;
    end
  end

  // counter parks on the last step until the switches move
  a_step_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    step <= last_step
  );

  // the display never carries old digits into a new sequence
  a_blank_after_restart: assert property (
    @(posedge clk) disable iff (!rst_n)
    restart |=> (digits == all_blank)
  );

endmodule

//--- div10_step.sv
`include "dbg_defines.svh"

module div10_step (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [`DBG_VAL_W-1:0] div_in,
  output logic [`DBG_VAL_W-1:0] quotient,
  output logic [3:0]            remainder
);

  localparam logic [`DBG_VAL_W-1:0] ten = `DBG_VAL_W'(10);

  // one division per clock
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      quotient <= '0;
    end else begin
      quotient <= div_in / ten;
    end
  end

  // decimal digit of the stored quotient, ready before the next edge
  assign remainder = 4'(quotient % ten);

  // digit feeds seg_of_digit, anything above nine would show blank
  a_remainder_digit: assert property (
    @(posedge clk) disable iff (!rst_n)
    remainder < 4'd10
  );

endmodule

//--- stage_select.sv
`include "dbg_defines.svh"

module stage_select
  import dbg_pkg::*;
(
  input  logic [`DBG_SW_W-1:0]  sw,
  input  probe_bank_t           probes,
  input  logic [`DBG_VAL_W-1:0] reg_value,
  output panel_ctrl_t           ctrl,
  output logic [`DBG_VAL_W-1:0] target_value,
  output logic [`DBG_OP_W-1:0]  opcode
);

  stage_probe_t sel_probe;

  // switch fields
  always_comb begin
    ctrl.manual_clk = sw[`DBG_SW_MANUAL];
    ctrl.show_reg   = sw[`DBG_SW_SHOW_REG];
    ctrl.stage_sel  = sw[2:0];
  end

  // stage mux, unused codes fall through to zero
  always_comb begin
    sel_probe = '0;
    for (int i = 0; i < `DBG_NUM_STAGES; i++) begin
      if (ctrl.stage_sel == i[2:0]) begin
        sel_probe = probes[i];
      end
    end
  end

  // register mode replaces the pc with the register value
  always_comb begin
    if (ctrl.show_reg) begin
      target_value = reg_value;
    end else begin
      target_value = {{(`DBG_VAL_W - `DBG_PC_W){1'b0}}, sel_probe.pc};
    end
  end

  // opcode goes to the LEDs regardless of mode
  assign opcode = sel_probe.opcode;

endmodule

//--- dbg_pkg.sv
`include "dbg_defines.svh"

package dbg_pkg;

  // pc and opcode seen at one pipeline stage
  typedef struct packed {
    logic [`DBG_PC_W-1:0] pc;
    logic [`DBG_OP_W-1:0] opcode;
  } stage_probe_t;

  // index 0 is fetch, index 6 is writeback
  typedef stage_probe_t [`DBG_NUM_STAGES-1:0] probe_bank_t;

  // decoded switch settings
  typedef struct packed {
    logic       manual_clk;
    logic       show_reg;
    logic [2:0] stage_sel;
  } panel_ctrl_t;

  // active low segments, bit 0 is segment a
  typedef logic [6:0] seg_t;

  // index 0 drives HEX0, the units digit
  typedef seg_t [`DBG_NUM_DIGITS-1:0] hex_bank_t;

  localparam seg_t seg_blank = 7'b1111111;

  function automatic seg_t seg_of_digit(input logic [3:0] digit);
    seg_t seg;
    case (digit)
      4'd0: seg = 7'b1000000;
      4'd1: seg = 7'b1111001;
      4'd2: seg = 7'b0100100;
      4'd3: seg = 7'b0110000;
      4'd4: seg = 7'b0011001;
      4'd5: seg = 7'b0010010;
      4'd6: seg = 7'b0000010;
      4'd7: seg = 7'b1111000;
      4'd8: seg = 7'b0000000;
      4'd9: seg = 7'b0010000;
      default: seg = seg_blank;
    endcase
    return seg;
  endfunction

endpackage

//--- dbg_defines.svh
`ifndef DBG_DEFINES_SVH
`define DBG_DEFINES_SVH

// probe widths from the pipeline
`define DBG_PC_W 7
`define DBG_OP_W 7

// register value and divider width
`define DBG_VAL_W 20

`define DBG_NUM_STAGES 7
`define DBG_NUM_DIGITS 6

// board switches and their roles
`define DBG_SW_W 10
`define DBG_SW_SHOW_REG 8
`define DBG_SW_MANUAL 9

`endif
